/* body/collision_check.sv */
`default_nettype none

module collision_check
    import snake_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  coord_t [MAX_LEN-1:0] body_x,
    input  coord_t [MAX_LEN-1:0] body_y,
    input  len_t                 length,
    output logic                 hit
);

    logic wall_hit;
    logic obst_hit;
    logic self_hit;

    assign wall_hit = (body_x[0] >= WALL_X) || (body_x[0] <= -WALL_X) ||
                      (body_y[0] >= WALL_Y_TOP) || (body_y[0] <= WALL_Y_BOT);

    assign obst_hit = (body_x[0] > -OBST_HALF) && (body_x[0] < OBST_HALF) &&
                      (body_y[0] > -OBST_HALF) && (body_y[0] < OBST_HALF);

    // head against active segments only
    always_comb begin
        self_hit = 1'b0;
        for (int i = 1; i < MAX_LEN; i++) begin
            if (i < length && body_x[i] == body_x[0] && body_y[i] == body_y[0])
                self_hit = 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET)
            hit <= 1'b0;
        else
            hit <= wall_hit | obst_hit | self_hit;
    end

endmodule

`default_nettype wire

/* body/snake_body.sv */
`default_nettype none

module snake_body
    import snake_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 move_tick,
    input  dir_t                 dir,
    input  logic                 eaten,
    output coord_t [MAX_LEN-1:0] body_x,
    output coord_t [MAX_LEN-1:0] body_y,
    output len_t                 length
);

    // start x of segment i, spare segments stack on the tail
    function automatic coord_t start_x(input int i);
        int k;
        k = (i > START_LEN - 1) ? START_LEN - 1 : i;
        return coord_t'(HEAD_X0 - k * SPACE);
    endfunction

    always_ff @(posedge CLK) begin
        if (RESET) begin
            length <= len_t'(START_LEN);
        end else if (eaten && length < len_t'(MAX_LEN)) begin
            length <= length + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < MAX_LEN; i++) begin
                body_x[i] <= start_x(i);
                body_y[i] <= coord_t'(HEAD_Y0);
            end
        end else if (move_tick && dir != DIR_NONE) begin
            case (dir)
                DIR_RIGHT: body_x[0] <= coord_t'(body_x[0] + SPACE);
                DIR_LEFT:  body_x[0] <= coord_t'(body_x[0] - SPACE);
                DIR_UP:    body_y[0] <= coord_t'(body_y[0] + SPACE);
                DIR_DOWN:  body_y[0] <= coord_t'(body_y[0] - SPACE);
                default: begin
                    body_x[0] <= body_x[0];
                    body_y[0] <= body_y[0];
                end
            endcase
            for (int i = 1; i < MAX_LEN; i++) begin
                if (i < length) begin
                    body_x[i] <= body_x[i-1];
                    body_y[i] <= body_y[i-1];
                end else begin
                    // inactive, parked on the tail
                    body_x[i] <= body_x[3];
                    body_y[i] <= body_y[3];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* common/snake_pkg.sv */
`default_nettype none

package snake_pkg;

    // grid coordinates, centre of the board is (0, 0)
    typedef logic signed [11:0] coord_t;
    typedef logic [4:0]         len_t;

    localparam int SPACE     = 30;  // one grid step
    localparam int MAX_LEN   = 20;
    localparam int START_LEN = 5;

    // head start, body trails to the left
    localparam int HEAD_X0 = 120;
    localparam int HEAD_Y0 = -90;

    // head dies at or beyond these
    localparam int WALL_X     = 375;
    localparam int WALL_Y_TOP = 225;
    localparam int WALL_Y_BOT = -275;

    localparam int OBST_HALF = 60;  // centre block, open bounds

    // where food may sit
    localparam int FOOD_X_MAX = 360;
    localparam int FOOD_Y_TOP = 220;
    localparam int FOOD_Y_BOT = -275;
    localparam int FOOD_OFF   = 1000;

    localparam int RDM_LIMIT = 500;

    typedef enum logic [1:0] {
        G_IDLE,
        G_PLAY,
        G_OVER
    } game_state_t;

    typedef enum logic [2:0] {
        DIR_NONE,
        DIR_RIGHT,
        DIR_LEFT,
        DIR_UP,
        DIR_DOWN
    } dir_t;

    // food placement machine
    typedef enum logic {
        F_INIT,
        F_WAIT
    } food_state_t;

endpackage

`default_nettype wire

/* hdl/food_unit.sv */
`default_nettype none

module food_unit
    import snake_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 btn_left,
    input  logic                 btn_right,
    input  logic                 btn_up,
    input  logic                 btn_down,
    input  coord_t [MAX_LEN-1:0] body_x,
    input  coord_t [MAX_LEN-1:0] body_y,
    output coord_t               food_x,
    output coord_t               food_y,
    output logic                 eaten
);

    food_state_t       state;
    logic signed [9:0] rdm_cnt;  // free running, -500..501
    logic              food_ok;  // food passed the check last cycle
    logic              any_btn;
    logic              out_area;
    logic              in_obst;
    logic              on_body;
    logic              on_head;

    assign any_btn = btn_left | btn_right | btn_up | btn_down;

    assign out_area = (food_x > FOOD_X_MAX) || (food_x < -FOOD_X_MAX) ||
                      (food_y > FOOD_Y_TOP) || (food_y < FOOD_Y_BOT);

    assign in_obst = (food_x > -OBST_HALF) && (food_x < OBST_HALF) &&
                     (food_y > -OBST_HALF) && (food_y < OBST_HALF);

    assign on_head = (food_x == body_x[0]) && (food_y == body_y[0]);

    always_comb begin
        on_body = 1'b0;
        for (int i = 0; i < MAX_LEN; i++) begin
            if (food_x == body_x[i] && food_y == body_y[i])
                on_body = 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET)
            rdm_cnt <= '0;
        else if (rdm_cnt > RDM_LIMIT)
            rdm_cnt <= 10'(-RDM_LIMIT);
        else
            rdm_cnt <= rdm_cnt + 10'sd1;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= F_INIT;
            food_x  <= coord_t'(FOOD_OFF);
            food_y  <= coord_t'(FOOD_OFF);
            food_ok <= 1'b0;
            eaten   <= 1'b0;
        end else begin
            eaten <= 1'b0;
            case (state)
                F_INIT: begin
                    food_x  <= coord_t'(FOOD_OFF);
                    food_y  <= coord_t'(FOOD_OFF);
                    food_ok <= 1'b0;
                    if (any_btn)
                        state <= F_WAIT;
                end
                default: begin
                    if (food_ok && on_head) begin
                        eaten   <= 1'b1;
                        food_x  <= coord_t'((rdm_cnt % 11) * SPACE);
                        food_y  <= coord_t'((rdm_cnt % 8) * SPACE);
                        food_ok <= 1'b0;
                    end else if (out_area || in_obst || on_body) begin
                        food_x  <= coord_t'((rdm_cnt % 16) * SPACE); // re-roll
                        food_y  <= coord_t'((rdm_cnt % 11) * SPACE);
                        food_ok <= 1'b0;
                    end else begin
                        food_ok <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/move_timer.sv */
`default_nettype none

module move_timer #(
    parameter int SLOW_WAIT = 66_666_666
) (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       pause,
    input  logic [1:0] speed_ctrl,
    output logic       move_tick
);

    localparam int CW = $clog2(SLOW_WAIT + 1);

    logic [CW-1:0] wait_cnt;
    logic [CW-1:0] counter;

    always_comb begin
        case (speed_ctrl)
            2'd0:    wait_cnt = CW'(SLOW_WAIT);
            2'd1:    wait_cnt = CW'(SLOW_WAIT * 3 / 4);
            2'd2:    wait_cnt = CW'(SLOW_WAIT / 2);
            default: wait_cnt = CW'(SLOW_WAIT * 3 / 8);
        endcase
    end

    // one pulse every wait_cnt+1 cycles
    always_ff @(posedge CLK) begin
        if (RESET || pause) begin
            counter   <= '0;
            move_tick <= 1'b0;
        end else if (counter >= wait_cnt) begin
            counter   <= '0;
            move_tick <= 1'b1;
        end else begin
            counter   <= counter + 1'b1;
            move_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/snake_game.sv */
`default_nettype none

module snake_game
    import snake_pkg::*;
#(
    parameter int SLOW_WAIT = 66_666_666
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        btn_left,
    input  logic        btn_right,
    input  logic        btn_up,
    input  logic        btn_down,
    input  logic        pause,
    input  logic [1:0]  speed_ctrl,
    output coord_t      head_x,
    output coord_t      head_y,
    output coord_t      food_x,
    output coord_t      food_y,
    output len_t        length,
    output game_state_t game_state,
    output logic        eaten
);

    logic                 move_tick;
    logic                 hit;
    dir_t                 dir;
    coord_t [MAX_LEN-1:0] body_x;
    coord_t [MAX_LEN-1:0] body_y;

    assign head_x = body_x[0];
    assign head_y = body_y[0];

    move_timer #(
        .SLOW_WAIT(SLOW_WAIT)
    ) move_timer_inst (
        .CLK        (CLK),
        .RESET      (RESET),
        .pause      (pause),
        .speed_ctrl (speed_ctrl),
        .move_tick  (move_tick)
    );

    steer_decode steer_decode_inst (
        .CLK        (CLK),
        .RESET      (RESET),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_up     (btn_up),
        .btn_down   (btn_down),
        .hit        (hit),
        .dir        (dir),
        .game_state (game_state)
    );

    snake_body snake_body_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .move_tick (move_tick),
        .dir       (dir),
        .eaten     (eaten),
        .body_x    (body_x),
        .body_y    (body_y),
        .length    (length)
    );

    collision_check collision_check_inst (
        .CLK    (CLK),
        .RESET  (RESET),
        .body_x (body_x),
        .body_y (body_y),
        .length (length),
        .hit    (hit)
    );

    food_unit food_unit_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .body_x    (body_x),
        .body_y    (body_y),
        .food_x    (food_x),
        .food_y    (food_y),
        .eaten     (eaten)
    );

endmodule

`default_nettype wire

/* hdl/steer_decode.sv */
`default_nettype none

module steer_decode
    import snake_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        btn_left,
    input  logic        btn_right,
    input  logic        btn_up,
    input  logic        btn_down,
    input  logic        hit,
    output dir_t        dir,
    output game_state_t game_state
);

    logic any_btn;

    assign any_btn = btn_left | btn_right | btn_up | btn_down;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            game_state <= G_IDLE;
            dir        <= DIR_NONE;
        end else begin
            case (game_state)
                G_IDLE: begin
                    dir <= DIR_NONE;
                    if (any_btn)
                        game_state <= G_PLAY;
                end
                G_PLAY: begin
                    if (hit) begin
                        game_state <= G_OVER;
                        dir        <= DIR_NONE;
                    end else begin
                        case (dir)
                            DIR_NONE: begin
                                // snake faces right at start, so left means right too
                                if (btn_left || btn_right)
                                    dir <= DIR_RIGHT;
                                else if (btn_up)
                                    dir <= DIR_UP;
                                else if (btn_down)
                                    dir <= DIR_DOWN;
                            end
                            DIR_RIGHT, DIR_LEFT: begin
                                if (btn_up)
                                    dir <= DIR_UP;
                                else if (btn_down)
                                    dir <= DIR_DOWN;
                            end
                            DIR_UP, DIR_DOWN: begin
                                if (btn_left)
                                    dir <= DIR_LEFT;
                                else if (btn_right)
                                    dir <= DIR_RIGHT;
                            end
                            default: dir <= DIR_NONE;
                        endcase
                    end
                end
                G_OVER: begin
                    dir <= DIR_NONE; // frozen until reset
                end
                default: begin
                    game_state <= G_IDLE;
                    dir        <= DIR_NONE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb.f */
common/snake_pkg.sv
hdl/move_timer.sv
hdl/steer_decode.sv
body/snake_body.sv
body/collision_check.sv
hdl/food_unit.sv
hdl/snake_game.sv
tb/tb_clock.sv
tb/snake_game_asserts.sv
tb/snake_game_tb.sv

/* tb/snake_game_asserts.sv */
`default_nettype none

module snake_game_asserts
    import snake_pkg::*;
(
    input logic        CLK,
    input logic        RESET,
    input coord_t      head_x,
    input coord_t      head_y,
    input len_t        length,
    input game_state_t game_state,
    input logic        eaten
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0; // polled by the testbench top

    eaten_pulse: assert property (@(posedge CLK) disable iff (RESET)
        eaten |=> !eaten)
    else begin
        $error("eaten stayed high for more than one cycle");
        fail_count++;
    end

    over_holds: assert property (@(posedge CLK) disable iff (RESET)
        game_state == G_OVER |=> game_state == G_OVER)
    else begin
        $error("game left G_OVER without a reset");
        fail_count++;
    end

    length_range: assert property (@(posedge CLK) disable iff (RESET)
        length >= START_LEN && length <= MAX_LEN)
    else begin
        $error("length outside its legal range");
        fail_count++;
    end

    // one grid step along exactly one axis
    head_step: assert property (@(posedge CLK) disable iff (RESET)
        (head_x != $past(head_x) || head_y != $past(head_y)) |->
            (head_y == $past(head_y) &&
             (head_x == $past(head_x) + SPACE || head_x == $past(head_x) - SPACE)) ||
            (head_x == $past(head_x) &&
             (head_y == $past(head_y) + SPACE || head_y == $past(head_y) - SPACE)))
    else begin
        $error("head moved by something other than one grid step");
        fail_count++;
    end

endmodule

bind snake_game snake_game_asserts asserts_inst (
    .CLK        (CLK),
    .RESET      (RESET),
    .head_x     (head_x),
    .head_y     (head_y),
    .length     (length),
    .game_state (game_state),
    .eaten      (eaten)
);

`default_nettype wire

/* tb/snake_game_tb.sv */
`default_nettype none

module snake_game_tb
    import snake_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SLOW_WAIT      = 80;
    localparam int TIMEOUT_CYCLES = 20000; // ~150 moves of up to 81 cycles, plus margin
    localparam int BTN_LEFT       = 0;
    localparam int BTN_RIGHT      = 1;
    localparam int BTN_UP         = 2;
    localparam int BTN_DOWN       = 3;
    localparam int ROW_LOW        = -150;
    localparam int ROW_HIGH       = 150;

    logic        CLK;
    logic        RESET;
    logic        btn_left;
    logic        btn_right;
    logic        btn_up;
    logic        btn_down;
    logic        pause;
    logic [1:0]  speed_ctrl;
    coord_t      head_x;
    coord_t      head_y;
    coord_t      food_x;
    coord_t      food_y;
    len_t        length;
    game_state_t game_state;
    logic        eaten;

    int cycle_count = 0;
    int eat_count   = 0;
    int exp_x;
    int exp_y;

    tb_clock #(.PERIOD(8)) tb_clock_inst (.CLK(CLK));

    snake_game #(
        .SLOW_WAIT(SLOW_WAIT)
    ) snake_game_inst (
        .CLK        (CLK),
        .RESET      (RESET),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_up     (btn_up),
        .btn_down   (btn_down),
        .pause      (pause),
        .speed_ctrl (speed_ctrl),
        .head_x     (head_x),
        .head_y     (head_y),
        .food_x     (food_x),
        .food_y     (food_y),
        .length     (length),
        .game_state (game_state),
        .eaten      (eaten)
    );

    always @(posedge CLK) begin
        if (RESET)
            eat_count <= 0;
        else if (eaten)
            eat_count <= eat_count + 1;
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1);
        end else if (snake_game_inst.asserts_inst.fail_count != 0) begin
            $display("a bound assertion on the game outputs failed");
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    task automatic check_eq(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("[ERROR] %0t: %s: got %0d, expected %0d", $time, what, got, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // move wait per speed setting with SLOW_WAIT at 80
    function automatic int wait_for_speed(input int s);
        case (s)
            0:       return 80;
            1:       return 60;
            2:       return 40;
            default: return 30;
        endcase
    endfunction

    function automatic bit food_placed(input int x, input int y);
        bit on_grid;
        bit in_area;
        bit in_block;
        bit on_start;
        on_grid  = (x % SPACE == 0) && (y % SPACE == 0);
        in_area  = x <= FOOD_X_MAX && x >= -FOOD_X_MAX && y <= FOOD_Y_TOP && y >= FOOD_Y_BOT;
        in_block = x > -OBST_HALF && x < OBST_HALF && y > -OBST_HALF && y < OBST_HALF;
        on_start = y == HEAD_Y0 && x <= HEAD_X0 && x >= HEAD_X0 - (START_LEN - 1) * SPACE;
        return on_grid && in_area && !in_block && !on_start;
    endfunction

    task automatic apply_reset(input logic [1:0] spd);
        @(negedge CLK);
        RESET      = 1'b1;
        btn_left   = 1'b0;
        btn_right  = 1'b0;
        btn_up     = 1'b0;
        btn_down   = 1'b0;
        pause      = 1'b0;
        speed_ctrl = spd;
        repeat (4) @(negedge CLK);
        RESET = 1'b0;
        exp_x = HEAD_X0;
        exp_y = HEAD_Y0;
    endtask

    task automatic press_button(input int b);
        btn_left  = (b == BTN_LEFT);
        btn_right = (b == BTN_RIGHT);
        btn_up    = (b == BTN_UP);
        btn_down  = (b == BTN_DOWN);
        @(negedge CLK);
        btn_left  = 1'b0;
        btn_right = 1'b0;
        btn_up    = 1'b0;
        btn_down  = 1'b0;
    endtask

    task automatic wait_head_change(output int gap);
        coord_t last_x;
        coord_t last_y;
        last_x = head_x;
        last_y = head_y;
        gap = 0;
        do begin
            @(negedge CLK);
            gap++;
        end while (head_x == last_x && head_y == last_y);
    endtask

    task automatic follow_moves(input int dx, input int dy, input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            wait_head_change(gap);
            exp_x += dx;
            exp_y += dy;
            check_eq("head x", head_x, exp_x);
            check_eq("head y", head_y, exp_y);
            check_eq("state while moving", game_state, G_PLAY);
        end
    endtask

    task automatic steer_and_move(input int b, input int dx, input int dy, input int n);
        if (n > 0) begin
            press_button(b);
            follow_moves(dx, dy, n);
        end
    endtask

    // called at the negedge that saw the fatal head change
    task automatic expect_game_over();
        @(negedge CLK);
        check_eq("state one cycle after hit move", game_state, G_PLAY);
        @(negedge CLK);
        check_eq("state two cycles after hit move", game_state, G_OVER);
    endtask

    task automatic reset_and_idle();
        apply_reset(2'd3);
        check_eq("state after reset", game_state, G_IDLE);
        check_eq("head x after reset", head_x, HEAD_X0);
        check_eq("head y after reset", head_y, HEAD_Y0);
        check_eq("length after reset", length, START_LEN);
        check_eq("eaten after reset", eaten, 0);
        check_eq("food x before start", food_x, FOOD_OFF);
        press_button(BTN_LEFT);
        check_eq("state after first button", game_state, G_PLAY);
        repeat (3 * (wait_for_speed(3) + 1)) begin
            @(negedge CLK);
            check_eq("head x without direction", head_x, HEAD_X0);
            check_eq("head y without direction", head_y, HEAD_Y0);
        end
    endtask

    task automatic movement_and_speed();
        int spd;
        int gap;
        spd = $urandom % 4;
        apply_reset(2'(spd));
        press_button(BTN_UP);
        steer_and_move(BTN_UP, 0, SPACE, 1); // phase of first tick unknown
        repeat (3) begin
            wait_head_change(gap);
            exp_y += SPACE;
            check_eq("head y moving up", head_y, exp_y);
            check_eq("cycles between moves", gap, wait_for_speed(spd) + 1);
        end
    endtask

    task automatic pause_and_reversal();
        int period;
        apply_reset(2'd2);
        period = wait_for_speed(2) + 1;
        press_button(BTN_UP);
        steer_and_move(BTN_UP, 0, SPACE, 1);
        pause = 1'b1;
        repeat (3 * period) begin
            @(negedge CLK);
            check_eq("head x in pause", head_x, exp_x);
            check_eq("head y in pause", head_y, exp_y);
        end
        pause = 1'b0;
        follow_moves(0, SPACE, 1);
        steer_and_move(BTN_DOWN, 0, SPACE, 1); // reversal, still going up
    endtask

    task automatic eat_food();
        int fx;
        int fy;
        int row;
        apply_reset(2'd3);
        press_button(BTN_UP);
        fx = food_x;
        fy = food_y;
        while (!food_placed(fx, fy)) begin
            @(negedge CLK);
            fx = food_x;
            fy = food_y;
        end
        @(negedge CLK);
        check_eq("food x settled", food_x, fx);
        check_eq("food y settled", food_y, fy);
        if (fx == HEAD_X0) begin
            if (fy > HEAD_Y0)
                steer_and_move(BTN_UP, 0, SPACE, (fy - HEAD_Y0) / SPACE);
            else
                steer_and_move(BTN_DOWN, 0, -SPACE, (HEAD_Y0 - fy) / SPACE);
        end else begin
            row = (fy <= 0) ? ROW_LOW : ROW_HIGH; // stay clear of the obstacle
            if (row < HEAD_Y0)
                steer_and_move(BTN_DOWN, 0, -SPACE, (HEAD_Y0 - row) / SPACE);
            else
                steer_and_move(BTN_UP, 0, SPACE, (row - HEAD_Y0) / SPACE);
            if (fx > HEAD_X0)
                steer_and_move(BTN_RIGHT, SPACE, 0, (fx - HEAD_X0) / SPACE);
            else
                steer_and_move(BTN_LEFT, -SPACE, 0, (HEAD_X0 - fx) / SPACE);
            if (fy > row)
                steer_and_move(BTN_UP, 0, SPACE, (fy - row) / SPACE);
            else
                steer_and_move(BTN_DOWN, 0, -SPACE, (row - fy) / SPACE);
        end
        repeat (3) @(negedge CLK);
        check_eq("eaten pulses", eat_count, 1);
        check_eq("length after eating", length, START_LEN + 1);
        fx = food_x;
        fy = food_y;
        check_eq("new food x on grid", fx % SPACE, 0);
        check_eq("new food y on grid", fy % SPACE, 0);
    endtask

    task automatic wall_death();
        apply_reset(2'd3);
        press_button(BTN_RIGHT);
        steer_and_move(BTN_RIGHT, SPACE, 0, 8);
        check_eq("head x at last column", head_x, 360);
        follow_moves(SPACE, 0, 1);
        expect_game_over();
        repeat (3 * (wait_for_speed(3) + 1)) begin
            @(negedge CLK);
            check_eq("frozen head x", head_x, 390);
            check_eq("frozen head y", head_y, HEAD_Y0);
            check_eq("state stays over", game_state, G_OVER);
        end
    endtask

    task automatic obstacle_death();
        apply_reset(2'd3);
        press_button(BTN_UP);
        steer_and_move(BTN_UP, 0, SPACE, 2);
        steer_and_move(BTN_LEFT, -SPACE, 0, 3); // ends on (30, -30)
        expect_game_over();
    endtask

    initial begin
        RESET      = 1'b1;
        btn_left   = 1'b0;
        btn_right  = 1'b0;
        btn_up     = 1'b0;
        btn_down   = 1'b0;
        pause      = 1'b0;
        speed_ctrl = 2'd0;
        void'($urandom(49));
        reset_and_idle();
        movement_and_speed();
        pause_and_reversal();
        eat_food();
        wall_death();
        obstacle_death();
        if (snake_game_inst.asserts_inst.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic CLK
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

endmodule

`default_nettype wire
